//--- list.f
hdl/instr_regmap_pkg.sv
hdl/instr_stats_pkg.sv
hdl/usb_stats.sv
hdl/drive_error_stats.sv
hdl/cmd_latency_stats.sv
hdl/instr_reg_bank.sv
hdl/instrumentation_regs.sv
verification/instr_properties.sv
verification/instr_checker.sv
verification/instrumentation_regs_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= instrumentation_regs_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) && echo "Simulation PASSED" || \
		(echo "Simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/instrumentation_regs_tb.sv
`timescale 1ns/1ps

module instrumentation_regs_tb import instr_regmap_pkg::*, instr_stats_pkg::*; ();

    typedef enum logic [2:0] {
        op_beats_rx, op_beats_tx, op_stall, op_errors, op_cmd, op_clear, op_read, op_read_model
    } op_kind_e;

    // Error steps pack {usb, timeout, crc, hdd, fdd} in arg[4:0] and the cycle count in arg[15:8]
    typedef struct packed {
        op_kind_e    kind;
        logic [31:0] arg;
        logic [31:0] expected;
    } step_t;

    logic                  clk;
    logic                  rst_n;
    logic [bus_data_w-1:0] reg_addr;
    logic [bus_data_w-1:0] reg_wdata;
    logic                  reg_we;
    logic                  reg_re;
    logic [bus_data_w-1:0] reg_rdata;
    logic                  reg_ready;
    logic                  usb_rx_valid;
    logic                  usb_rx_ready;
    logic                  usb_tx_valid;
    logic                  usb_tx_ready;
    logic                  usb_error;
    logic                  fdd_error;
    logic                  hdd_error;
    logic                  crc_error;
    logic                  timeout_error;
    logic                  cmd_start;
    logic                  cmd_done;
    logic                  counters_reset;

    logic [bus_data_w-1:0] exp_value;
    logic [8*16-1:0]       test_name;
    logic                  report;
    int                    pass_count;
    int                    fail_count;
    int                    checks_done;
    step_t                 steps[$];
    integer                seed;
    int unsigned           rx_beats;
    int unsigned           tx_beats;
    int unsigned           usb_errs;
    int unsigned           cycle_count;
    int unsigned           cycle_limit;

    instrumentation_regs i_instrumentation_regs (.*);

    instr_checker i_instr_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_re         (reg_re),
        .reg_we         (reg_we),
        .reg_ready      (reg_ready),
        .reg_rdata      (reg_rdata),
        .counters_reset (counters_reset),
        .exp_value      (exp_value),
        .test_name      (test_name),
        .report         (report),
        .pass_count     (pass_count),
        .fail_count     (fail_count),
        .checks_done    (checks_done)
    );

    bind instr_reg_bank instr_properties i_instr_properties (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ============================================================
    // Helpers
    // ============================================================

    function automatic void add_step(input op_kind_e kind, input logic [31:0] arg,
                                     input logic [31:0] expected);
        step_t s;
        s.kind     = kind;
        s.arg      = arg;
        s.expected = expected;
        steps.push_back(s);
    endfunction

    function automatic logic [8*16-1:0] reg_name(input logic [reg_offset_w-1:0] off);
        case (off)
            reg_version:         return "version";
            reg_control:         return "control";
            reg_usb_rx_bytes_lo: return "usb_rx_bytes_lo";
            reg_usb_rx_bytes_hi: return "usb_rx_bytes_hi";
            reg_usb_tx_bytes_lo: return "usb_tx_bytes_lo";
            reg_usb_tx_bytes_hi: return "usb_tx_bytes_hi";
            reg_usb_rx_packets:  return "usb_rx_packets";
            reg_usb_tx_packets:  return "usb_tx_packets";
            reg_usb_errors:      return "usb_errors";
            reg_lat_min:         return "lat_min";
            reg_lat_max:         return "lat_max";
            reg_lat_count:       return "lat_count";
            reg_lat_last:        return "lat_last";
            reg_err_fdd:         return "err_fdd";
            reg_err_hdd:         return "err_hdd";
            reg_err_crc:         return "err_crc";
            reg_err_timeout:     return "err_timeout";
            reg_err_total:       return "err_total";
            default:             return "unmapped";
        endcase
    endfunction

    // Expected USB values from the beats and errors driven so far
    function automatic logic [31:0] usb_model_value(input logic [reg_offset_w-1:0] off);
        case (off)
            reg_usb_rx_bytes_lo: return rx_beats * bytes_per_beat;
            reg_usb_tx_bytes_lo: return tx_beats * bytes_per_beat;
            reg_usb_rx_packets:  return rx_beats;
            reg_usb_tx_packets:  return tx_beats;
            reg_usb_errors:      return usb_errs;
            default:             return 32'h0;
        endcase
    endfunction

    task automatic idle_inputs();
        usb_rx_valid  = 1'b0;
        usb_rx_ready  = 1'b0;
        usb_tx_valid  = 1'b0;
        usb_tx_ready  = 1'b0;
        usb_error     = 1'b0;
        fdd_error     = 1'b0;
        hdd_error     = 1'b0;
        crc_error     = 1'b0;
        timeout_error = 1'b0;
        cmd_start     = 1'b0;
        cmd_done      = 1'b0;
    endtask

    task automatic drive_usb(input logic rx, input logic tx, input logic ready,
                             input int unsigned cycles);
        usb_rx_valid = rx;
        usb_rx_ready = rx & ready;
        usb_tx_valid = tx;
        usb_tx_ready = tx & ready;
        repeat (cycles) @(negedge clk);
        idle_inputs();
    endtask

    task automatic drive_errors(input logic [4:0] pattern, input int unsigned cycles);
        fdd_error     = pattern[0];
        hdd_error     = pattern[1];
        crc_error     = pattern[2];
        timeout_error = pattern[3];
        usb_error     = pattern[4];
        repeat (cycles) @(negedge clk);
        idle_inputs();
    endtask

    // Done arrives k cycles after the start cycle
    task automatic run_cmd(input int unsigned k);
        cmd_start = 1'b1;
        @(negedge clk);
        // A retrigger while timing must not restart the timer
        cmd_start = (k > 2);
        repeat (k - 1) begin
            @(negedge clk);
            cmd_start = 1'b0;
        end
        cmd_done = 1'b1;
        @(negedge clk);
        cmd_done = 1'b0;
    endtask

    task automatic clear_write();
        reg_addr  = 32'(reg_control);
        reg_wdata = 32'h1 << ctrl_clear_bit;
        reg_we    = 1'b1;
        test_name = "clear";
        @(negedge clk);
        reg_we    = 1'b0;
        reg_wdata = '0;
        @(negedge clk);
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] expected);
        int start_count;
        start_count = checks_done;
        reg_addr    = addr;
        reg_re      = 1'b1;
        exp_value   = expected;
        test_name   = reg_name(addr[reg_offset_w-1:0]);
        @(negedge clk);
        reg_re = 1'b0;
        wait (checks_done != start_count);
    endtask

    // ============================================================
    // Stimulus table
    // ============================================================

    task automatic build_table();
        // Reset values
        add_step(op_read, reg_version, 32'h0001_0000);
        add_step(op_read, 32'hABC0_0000, 32'h0001_0000);
        add_step(op_read, reg_control, 32'h0);
        add_step(op_read, reg_usb_rx_bytes_lo, 32'h0);
        add_step(op_read, reg_usb_rx_bytes_hi, 32'h0);
        add_step(op_read, reg_usb_tx_bytes_lo, 32'h0);
        add_step(op_read, reg_usb_tx_bytes_hi, 32'h0);
        add_step(op_read, reg_usb_rx_packets, 32'h0);
        add_step(op_read, reg_usb_tx_packets, 32'h0);
        add_step(op_read, reg_usb_errors, 32'h0);
        add_step(op_read, reg_lat_min, 32'hFFFF_FFFF);
        add_step(op_read, reg_lat_max, 32'h0);
        add_step(op_read, reg_lat_count, 32'h0);
        add_step(op_read, reg_lat_last, 32'h0);
        add_step(op_read, reg_err_fdd, 32'h0);
        add_step(op_read, reg_err_hdd, 32'h0);
        add_step(op_read, reg_err_crc, 32'h0);
        add_step(op_read, reg_err_timeout, 32'h0);
        add_step(op_read, reg_err_total, 32'h0);
        add_step(op_read, 32'h200, 32'hDEAD_BEEF);
        // Random USB traffic with stalled cycles in between
        add_step(op_beats_rx, 32'h0, 32'h0);
        add_step(op_stall, 32'd6, 32'h0);
        add_step(op_beats_tx, 32'h0, 32'h0);
        add_step(op_beats_rx, 32'h0, 32'h0);
        add_step(op_read_model, reg_usb_rx_bytes_lo, 32'h0);
        add_step(op_read_model, reg_usb_rx_bytes_hi, 32'h0);
        add_step(op_read_model, reg_usb_tx_bytes_lo, 32'h0);
        add_step(op_read_model, reg_usb_tx_bytes_hi, 32'h0);
        add_step(op_read_model, reg_usb_rx_packets, 32'h0);
        add_step(op_read_model, reg_usb_tx_packets, 32'h0);
        // fdd 3+2, hdd 2+4, crc 3+2, timeout 2, total 18
        add_step(op_errors, 32'h0305, 32'h0);
        add_step(op_errors, 32'h021F, 32'h0);
        add_step(op_errors, 32'h0402, 32'h0);
        add_step(op_read, reg_err_fdd, 32'd5);
        add_step(op_read, reg_err_hdd, 32'd6);
        add_step(op_read, reg_err_crc, 32'd5);
        add_step(op_read, reg_err_timeout, 32'd2);
        add_step(op_read, reg_err_total, 32'd18);
        add_step(op_read_model, reg_usb_errors, 32'h0);
        // Recorded latency is k-1
        add_step(op_cmd, 32'd5, 32'h0);
        add_step(op_cmd, 32'd2, 32'h0);
        add_step(op_cmd, 32'd9, 32'h0);
        add_step(op_read, reg_lat_last, 32'd8);
        add_step(op_read, reg_lat_min, 32'd1);
        add_step(op_read, reg_lat_max, 32'd8);
        add_step(op_read, reg_lat_count, 32'd3);
        // Software clear followed by fresh counting
        add_step(op_clear, 32'h0, 32'h0);
        add_step(op_read_model, reg_usb_rx_bytes_lo, 32'h0);
        add_step(op_read_model, reg_usb_rx_packets, 32'h0);
        add_step(op_read_model, reg_usb_tx_bytes_lo, 32'h0);
        add_step(op_read_model, reg_usb_tx_packets, 32'h0);
        add_step(op_read_model, reg_usb_errors, 32'h0);
        add_step(op_read, reg_lat_min, 32'hFFFF_FFFF);
        add_step(op_read, reg_lat_max, 32'h0);
        add_step(op_read, reg_lat_count, 32'h0);
        add_step(op_read, reg_lat_last, 32'h0);
        add_step(op_read, reg_err_fdd, 32'h0);
        add_step(op_read, reg_err_hdd, 32'h0);
        add_step(op_read, reg_err_crc, 32'h0);
        add_step(op_read, reg_err_timeout, 32'h0);
        add_step(op_read, reg_err_total, 32'h0);
        add_step(op_beats_tx, 32'h0, 32'h0);
        add_step(op_read_model, reg_usb_tx_packets, 32'h0);
        add_step(op_read_model, reg_usb_tx_bytes_lo, 32'h0);
        add_step(op_read_model, reg_usb_rx_packets, 32'h0);
    endtask

    task automatic apply_step(input step_t s);
        int unsigned beats;
        beats = 1 + ({$random(seed)} % 24);
        case (s.kind)
            op_beats_rx: begin
                drive_usb(1'b1, 1'b0, 1'b1, beats);
                rx_beats += beats;
            end
            op_beats_tx: begin
                drive_usb(1'b0, 1'b1, 1'b1, beats);
                tx_beats += beats;
            end
            op_stall:      drive_usb(1'b1, 1'b1, 1'b0, s.arg);
            op_errors: begin
                drive_errors(s.arg[4:0], s.arg[15:8]);
                if (s.arg[4]) usb_errs += s.arg[15:8];
            end
            op_cmd:        run_cmd(s.arg);
            op_clear: begin
                clear_write();
                rx_beats = 0;
                tx_beats = 0;
                usb_errs = 0;
            end
            op_read:       bus_read(s.arg, s.expected);
            op_read_model: bus_read(s.arg, usb_model_value(s.arg[reg_offset_w-1:0]));
            default:       ;
        endcase
    endtask

    task automatic finish_run(input logic timed_out);
        report = 1'b1;
        @(negedge clk);
        if (!timed_out && fail_count == 0 && checks_done > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // ============================================================
    // Run control
    // ============================================================

    initial begin : stimulus
        seed      = 32'ha3b7_55e2;
        rst_n     = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        reg_we    = 1'b0;
        reg_re    = 1'b0;
        exp_value = '0;
        test_name = '0;
        report    = 1'b0;
        rx_beats  = 0;
        tx_beats  = 0;
        usb_errs  = 0;
        idle_inputs();
        build_table();
        cycle_limit = steps.size() * 64 + 8;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        finish_run(1'b0);
    end

    initial begin : watchdog
        cycle_count = 0;
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the stimulus did not finish within %0d cycles", cycle_limit);
        finish_run(1'b1);
    end

endmodule

//--- verification/instr_checker.sv
`timescale 1ns/1ps

module instr_checker import instr_regmap_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [bus_data_w-1:0] reg_addr,
    input  logic [bus_data_w-1:0] reg_wdata,
    input  logic                  reg_re,
    input  logic                  reg_we,
    input  logic                  reg_ready,
    input  logic [bus_data_w-1:0] reg_rdata,
    input  logic                  counters_reset,
    input  logic [bus_data_w-1:0] exp_value,
    input  logic [8*16-1:0]       test_name,
    input  logic                  report,
    output int                    pass_count,
    output int                    fail_count,
    output int                    checks_done
);

    logic                  read_pending;
    logic                  clear_pending;
    logic [bus_data_w-1:0] exp_held;
    logic [8*16-1:0]       name_held;

    // Capture each access at the edge that samples it
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_pending  <= 1'b0;
            clear_pending <= 1'b0;
        end else begin
            read_pending  <= reg_re;
            clear_pending <= reg_we && (reg_addr[reg_offset_w-1:0] == reg_control)
                             && reg_wdata[ctrl_clear_bit];
            if (reg_re || reg_we) begin
                exp_held  <= exp_value;
                name_held <= test_name;
            end
        end
    end

    // Responses are compared on the falling edge after they settle
    always @(negedge clk) begin
        if (rst_n && read_pending) begin
            if (reg_ready !== 1'b1) begin
                $display("FAIL %0s: reg_ready did not rise after the read", name_held);
                fail_count++;
            end else if (reg_rdata !== exp_held) begin
                $display("Mismatch %0s: reg_rdata = 0x%08h, expected 0x%08h",
                         name_held, reg_rdata, exp_held);
                fail_count++;
            end else begin
                $display("PASS %0s: reg_rdata = 0x%08h", name_held, reg_rdata);
                pass_count++;
            end
            checks_done++;
        end
        if (rst_n && clear_pending) begin
            if (reg_ready !== 1'b1) begin
                $display("FAIL %0s: reg_ready did not rise after the write", name_held);
                fail_count++;
            end else if (counters_reset !== 1'b1) begin
                $display("FAIL %0s: counters_reset did not pulse after the write", name_held);
                fail_count++;
            end else begin
                $display("PASS %0s: counters_reset pulsed", name_held);
                pass_count++;
            end
            checks_done++;
        end
    end

    always @(posedge report) begin
        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
    end

endmodule

//--- verification/instr_properties.sv
`timescale 1ns/1ps

module instr_properties import instr_regmap_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  reg_re,
    input logic                  reg_we,
    input logic                  reg_ready,
    input logic                  counters_clear,
    input logic [bus_data_w-1:0] reg_rdata
);

    // Ready answers the access of the previous cycle only
    ready_follows_access: assert property (@(posedge clk) disable iff (!rst_n)
        reg_ready |-> $past(reg_re || reg_we))
        else $error("reg_ready rose without an access in the previous cycle");

    clear_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        counters_clear |=> !counters_clear)
        else $error("counters_clear stayed high for two cycles");

    rdata_known: assert property (@(posedge clk) disable iff (!rst_n)
        reg_ready |-> !$isunknown(reg_rdata))
        else $error("reg_rdata has unknown bits while reg_ready is high");

endmodule

//--- hdl/instrumentation_regs.sv
`timescale 1ns/1ps

module instrumentation_regs import instr_regmap_pkg::*, instr_stats_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // Register bus
    input  logic [bus_data_w-1:0] reg_addr,
    input  logic [bus_data_w-1:0] reg_wdata,
    input  logic                  reg_we,
    input  logic                  reg_re,
    output logic [bus_data_w-1:0] reg_rdata,
    output logic                  reg_ready,
    // USB probes
    input  logic                  usb_rx_valid,
    input  logic                  usb_rx_ready,
    input  logic                  usb_tx_valid,
    input  logic                  usb_tx_ready,
    input  logic                  usb_error,
    // Drive error probes
    input  logic                  fdd_error,
    input  logic                  hdd_error,
    input  logic                  crc_error,
    input  logic                  timeout_error,
    // Command timing
    input  logic                  cmd_start,
    input  logic                  cmd_done,
    output logic                  counters_reset
);

    logic               counters_clear;
    logic [total_w-1:0] rx_bytes;
    logic [total_w-1:0] tx_bytes;
    logic [count_w-1:0] rx_packets;
    logic [count_w-1:0] tx_packets;
    logic [count_w-1:0] usb_error_count;
    logic [count_w-1:0] err_fdd;
    logic [count_w-1:0] err_hdd;
    logic [count_w-1:0] err_crc;
    logic [count_w-1:0] err_timeout;
    logic [count_w-1:0] err_total;
    logic [count_w-1:0] lat_last;
    logic [count_w-1:0] lat_min;
    logic [count_w-1:0] lat_max;
    logic [count_w-1:0] lat_count;

    // Software clear is also exported to the rest of the controller
    assign counters_reset = counters_clear;

    // ==========================================================
    // Statistic banks
    // ==========================================================

    usb_stats i_usb_stats (
        .clk             (clk),
        .rst_n           (rst_n),
        .counters_clear  (counters_clear),
        .usb_rx_valid    (usb_rx_valid),
        .usb_rx_ready    (usb_rx_ready),
        .usb_tx_valid    (usb_tx_valid),
        .usb_tx_ready    (usb_tx_ready),
        .usb_error       (usb_error),
        .rx_bytes        (rx_bytes),
        .tx_bytes        (tx_bytes),
        .rx_packets      (rx_packets),
        .tx_packets      (tx_packets),
        .usb_error_count (usb_error_count)
    );

    drive_error_stats i_drive_error_stats (
        .clk            (clk),
        .rst_n          (rst_n),
        .counters_clear (counters_clear),
        .fdd_error      (fdd_error),
        .hdd_error      (hdd_error),
        .crc_error      (crc_error),
        .timeout_error  (timeout_error),
        .err_fdd        (err_fdd),
        .err_hdd        (err_hdd),
        .err_crc        (err_crc),
        .err_timeout    (err_timeout),
        .err_total      (err_total)
    );

    cmd_latency_stats i_cmd_latency_stats (
        .clk            (clk),
        .rst_n          (rst_n),
        .counters_clear (counters_clear),
        .cmd_start      (cmd_start),
        .cmd_done       (cmd_done),
        .lat_last       (lat_last),
        .lat_min        (lat_min),
        .lat_max        (lat_max),
        .lat_count      (lat_count)
    );

    // ==========================================================
    // Register bank
    // ==========================================================

    instr_reg_bank i_instr_reg_bank (
        .clk             (clk),
        .rst_n           (rst_n),
        .reg_addr        (reg_addr),
        .reg_wdata       (reg_wdata),
        .reg_we          (reg_we),
        .reg_re          (reg_re),
        .reg_rdata       (reg_rdata),
        .reg_ready       (reg_ready),
        .counters_clear  (counters_clear),
        .rx_bytes        (rx_bytes),
        .tx_bytes        (tx_bytes),
        .rx_packets      (rx_packets),
        .tx_packets      (tx_packets),
        .usb_error_count (usb_error_count),
        .err_fdd         (err_fdd),
        .err_hdd         (err_hdd),
        .err_crc         (err_crc),
        .err_timeout     (err_timeout),
        .err_total       (err_total),
        .lat_last        (lat_last),
        .lat_min         (lat_min),
        .lat_max         (lat_max),
        .lat_count       (lat_count)
    );

endmodule

//--- hdl/instr_reg_bank.sv
`timescale 1ns/1ps

module instr_reg_bank import instr_regmap_pkg::*, instr_stats_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [bus_data_w-1:0] reg_addr,
    input  logic [bus_data_w-1:0] reg_wdata,
    input  logic                  reg_we,
    input  logic                  reg_re,
    output logic [bus_data_w-1:0] reg_rdata,
    output logic                  reg_ready,
    output logic                  counters_clear,
    input  logic [total_w-1:0]    rx_bytes,
    input  logic [total_w-1:0]    tx_bytes,
    input  logic [count_w-1:0]    rx_packets,
    input  logic [count_w-1:0]    tx_packets,
    input  logic [count_w-1:0]    usb_error_count,
    input  logic [count_w-1:0]    err_fdd,
    input  logic [count_w-1:0]    err_hdd,
    input  logic [count_w-1:0]    err_crc,
    input  logic [count_w-1:0]    err_timeout,
    input  logic [count_w-1:0]    err_total,
    input  logic [count_w-1:0]    lat_last,
    input  logic [count_w-1:0]    lat_min,
    input  logic [count_w-1:0]    lat_max,
    input  logic [count_w-1:0]    lat_count
);

    reg_offset_e           offset;
    logic                  clear_req;
    logic [bus_data_w-1:0] read_value;

    // Only the low address bits select a register
    assign offset = reg_offset_e'(reg_addr[reg_offset_w-1:0]);

    assign clear_req = reg_we && (offset == reg_control) && reg_wdata[ctrl_clear_bit];

    // ==========================================================
    // Read multiplexer
    // ==========================================================

    always_comb begin
        case (offset)
            reg_version:         read_value = version_word;
            reg_control:         read_value = '0;
            reg_usb_rx_bytes_lo: read_value = rx_bytes[31:0];
            reg_usb_rx_bytes_hi: read_value = rx_bytes[63:32];
            reg_usb_tx_bytes_lo: read_value = tx_bytes[31:0];
            reg_usb_tx_bytes_hi: read_value = tx_bytes[63:32];
            reg_usb_rx_packets:  read_value = rx_packets;
            reg_usb_tx_packets:  read_value = tx_packets;
            reg_usb_errors:      read_value = usb_error_count;
            reg_lat_min:         read_value = lat_min;
            reg_lat_max:         read_value = lat_max;
            reg_lat_count:       read_value = lat_count;
            reg_lat_last:        read_value = lat_last;
            reg_err_fdd:         read_value = err_fdd;
            reg_err_hdd:         read_value = err_hdd;
            reg_err_crc:         read_value = err_crc;
            reg_err_timeout:     read_value = err_timeout;
            reg_err_total:       read_value = err_total;
            default:             read_value = unmapped_read_value;
        endcase
    end

    // ==========================================================
    // Ready pulse, clear pulse and read data
    // ==========================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_ready      <= 1'b0;
            counters_clear <= 1'b0;
            reg_rdata      <= '0;
        end else begin
            // One-cycle pulses, never stretched
            reg_ready      <= reg_re || reg_we;
            counters_clear <= clear_req;
            // Counters are sampled before any clear from the same access lands
            if (reg_re) begin
                reg_rdata <= read_value;
            end
        end
    end

endmodule

//--- hdl/cmd_latency_stats.sv
`timescale 1ns/1ps

module cmd_latency_stats import instr_stats_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               counters_clear,
    input  logic               cmd_start,
    input  logic               cmd_done,
    output logic [count_w-1:0] lat_last,
    output logic [count_w-1:0] lat_min,
    output logic [count_w-1:0] lat_max,
    output logic [count_w-1:0] lat_count
);

    lat_state_e         state;
    logic [count_w-1:0] timer;

    // ==========================================================
    // Tracker and cycle timer
    // ==========================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= lat_idle;
            timer     <= '0;
            lat_last  <= '0;
            lat_min   <= '1;
            lat_max   <= '0;
            lat_count <= '0;
        end else if (counters_clear) begin
            state     <= lat_idle;
            timer     <= '0;
            lat_last  <= '0;
            lat_min   <= '1;
            lat_max   <= '0;
            lat_count <= '0;
        end else begin
            case (state)
                lat_idle: begin
                    // Done without a command in flight is dropped
                    if (cmd_start) begin
                        state <= lat_timing;
                        timer <= '0;
                    end
                end
                lat_timing: begin
                    timer <= timer + 1'b1;
                    if (cmd_done) begin
                        state     <= lat_idle;
                        lat_last  <= timer;
                        lat_count <= lat_count + 1'b1;
                        if (timer < lat_min) lat_min <= timer;
                        if (timer > lat_max) lat_max <= timer;
                    end
                end
                default: state <= lat_idle;
            endcase
        end
    end

endmodule

//--- hdl/drive_error_stats.sv
`timescale 1ns/1ps

module drive_error_stats import instr_stats_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               counters_clear,
    input  logic               fdd_error,
    input  logic               hdd_error,
    input  logic               crc_error,
    input  logic               timeout_error,
    output logic [count_w-1:0] err_fdd,
    output logic [count_w-1:0] err_hdd,
    output logic [count_w-1:0] err_crc,
    output logic [count_w-1:0] err_timeout,
    output logic [count_w-1:0] err_total
);

    // Number of error inputs raised this cycle, 0 to 4
    logic [2:0] err_step;

    assign err_step = 3'(fdd_error) + 3'(hdd_error) + 3'(crc_error) + 3'(timeout_error);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_fdd     <= '0;
            err_hdd     <= '0;
            err_crc     <= '0;
            err_timeout <= '0;
            err_total   <= '0;
        end else if (counters_clear) begin
            err_fdd     <= '0;
            err_hdd     <= '0;
            err_crc     <= '0;
            err_timeout <= '0;
            err_total   <= '0;
        end else begin
            if (fdd_error)     err_fdd     <= err_fdd + 1'b1;
            if (hdd_error)     err_hdd     <= err_hdd + 1'b1;
            if (crc_error)     err_crc     <= err_crc + 1'b1;
            if (timeout_error) err_timeout <= err_timeout + 1'b1;
            // Running total kept here so the read path has no adder
            err_total <= err_total + count_w'(err_step);
        end
    end

endmodule

//--- hdl/usb_stats.sv
`timescale 1ns/1ps

module usb_stats import instr_stats_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               counters_clear,
    input  logic               usb_rx_valid,
    input  logic               usb_rx_ready,
    input  logic               usb_tx_valid,
    input  logic               usb_tx_ready,
    input  logic               usb_error,
    output logic [total_w-1:0] rx_bytes,
    output logic [total_w-1:0] tx_bytes,
    output logic [count_w-1:0] rx_packets,
    output logic [count_w-1:0] tx_packets,
    output logic [count_w-1:0] usb_error_count
);

    logic rx_beat;
    logic tx_beat;

    // A beat transfers when both sides agree
    assign rx_beat = usb_rx_valid && usb_rx_ready;
    assign tx_beat = usb_tx_valid && usb_tx_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_bytes        <= '0;
            tx_bytes        <= '0;
            rx_packets      <= '0;
            tx_packets      <= '0;
            usb_error_count <= '0;
        end else if (counters_clear) begin
            rx_bytes        <= '0;
            tx_bytes        <= '0;
            rx_packets      <= '0;
            tx_packets      <= '0;
            usb_error_count <= '0;
        end else begin
            if (rx_beat) begin
                rx_bytes   <= rx_bytes + total_w'(bytes_per_beat);
                rx_packets <= rx_packets + 1'b1;
            end
            if (tx_beat) begin
                tx_bytes   <= tx_bytes + total_w'(bytes_per_beat);
                tx_packets <= tx_packets + 1'b1;
            end
            if (usb_error) begin
                usb_error_count <= usb_error_count + 1'b1;
            end
        end
    end

endmodule

//--- hdl/instr_stats_pkg.sv
package instr_stats_pkg;

    // ==========================================================
    // Counter sizing
    // ==========================================================

    // Event counters and 64-bit byte totals
    localparam int count_w = 32;
    localparam int total_w = 64;

    // One 32-bit word per accepted USB beat
    localparam int bytes_per_beat = 4;

    // Command latency tracker
    typedef enum logic {
        lat_idle,
        lat_timing
    } lat_state_e;

endpackage

//--- hdl/instr_regmap_pkg.sv
package instr_regmap_pkg;

    // ==========================================================
    // Register bus geometry
    // ==========================================================

    localparam int bus_data_w   = 32;
    localparam int reg_offset_w = 12;

    // Byte offsets decoded from the low address bits
    typedef enum logic [reg_offset_w-1:0] {
        reg_version        = 12'h000,
        reg_control        = 12'h004,
        reg_usb_rx_bytes_lo = 12'h040,
        reg_usb_rx_bytes_hi = 12'h044,
        reg_usb_tx_bytes_lo = 12'h048,
        reg_usb_tx_bytes_hi = 12'h04C,
        reg_usb_rx_packets = 12'h050,
        reg_usb_tx_packets = 12'h054,
        reg_usb_errors     = 12'h058,
        reg_lat_min        = 12'h100,
        reg_lat_max        = 12'h104,
        reg_lat_count      = 12'h108,
        reg_lat_last       = 12'h10C,
        reg_err_fdd        = 12'h1C0,
        reg_err_hdd        = 12'h1C4,
        reg_err_crc        = 12'h1C8,
        reg_err_timeout    = 12'h1CC,
        reg_err_total      = 12'h1D0
    } reg_offset_e;

    // Fixed read values
    localparam logic [bus_data_w-1:0] version_word        = 32'h0001_0000;
    localparam logic [bus_data_w-1:0] unmapped_read_value = 32'hDEAD_BEEF;

    // Control register bit that clears all counters
    localparam int ctrl_clear_bit = 0;

endpackage
